/* m_ext_pkg.sv */
// Shared definitions for the M-extension divide path
// Default data width
// Divide operation encoding and op code width
// Iteration counter width of the divider
package m_ext_pkg;

    // Default data width, overridden through the top level parameter
    localparam int unsigned XLEN = 32;

    // Width of the op code coming from the execute stage
    localparam int unsigned ALU_D_OPS_W = 3;

    // Divide operation codes
    // Bit 2 is set for every divide request and starts the divider
    typedef enum logic [ALU_D_OPS_W-1:0] {
        ALU_D_OPS_NONE = 3'b000,  // No request
        ALU_D_OPS_DIV  = 3'b100,  // Signed quotient
        ALU_D_OPS_DIVU = 3'b101,  // Unsigned quotient
        ALU_D_OPS_REM  = 3'b110,  // Signed remainder
        ALU_D_OPS_REMU = 3'b111   // Unsigned remainder
    } alu_d_ops_e;

    // Counter width for one quotient bit per cycle
    // Counts from 0 up to width - 1
    function automatic int unsigned div_cnt_w(input int unsigned width);
        int unsigned cnt_w;
        if (width <= 2) begin
            cnt_w = 1;
        end else begin
            cnt_w = $clog2(width);
        end
        return cnt_w;
    endfunction

endpackage

/* divider.sv */
// Iterative unsigned restoring divider
// One quotient bit per cycle, shift and subtract
// Zero divisor finishes one cycle after start
// Abort returns the core to idle
module divider #(
    parameter int unsigned XLEN = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start_i,
    input  logic            abort_i,
    input  logic [XLEN-1:0] opr1_i,   // Dividend
    input  logic [XLEN-1:0] opr2_i,   // Divisor
    output logic            done_o,
    output logic [XLEN-1:0] quo_o,
    output logic [XLEN-1:0] rem_o,
    output logic            busy_o
);

    localparam int unsigned CNT_W = m_ext_pkg::div_cnt_w(XLEN);

    logic             busy_ff;
    logic             done_ff;
    logic [CNT_W-1:0] cnt_ff;
    logic [XLEN-1:0]  quo_ff;      // Dividend bits leave at the top, quotient bits enter below
    logic [XLEN-1:0]  rem_ff;
    logic [XLEN-1:0]  dvsr_ff;
    logic [XLEN:0]    rem_shift;
    logic [XLEN:0]    rem_sub;
    logic             sub_ok;
    logic             last_iter;

    // Partial remainder with the next dividend bit shifted in
    assign rem_shift = {rem_ff, quo_ff[XLEN-1]};
    assign rem_sub   = rem_shift - {1'b0, dvsr_ff};
    assign sub_ok    = rem_shift >= {1'b0, dvsr_ff};
    assign last_iter = cnt_ff == CNT_W'(XLEN - 1);

    always_ff @(posedge clk) begin
        if (!rst_n || abort_i) begin
            busy_ff <= 1'b0;
            done_ff <= 1'b0;
            cnt_ff  <= '0;
        end else begin
            done_ff <= 1'b0;              // Single cycle pulse
            if (start_i) begin
                busy_ff <= |opr2_i;
                done_ff <= ~|opr2_i;      // Zero divisor skips the iterations
                cnt_ff  <= '0;
            end else if (busy_ff) begin
                cnt_ff <= cnt_ff + 1'b1;
                if (last_iter) begin
                    busy_ff <= 1'b0;
                    done_ff <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            dvsr_ff <= opr2_i;
            if (opr2_i == '0) begin
                // RISC-V result for division by zero
                quo_ff <= '1;
                rem_ff <= opr1_i;
            end else begin
                quo_ff <= opr1_i;
                rem_ff <= '0;
            end
        end else if (busy_ff) begin
            quo_ff <= {quo_ff[XLEN-2:0], sub_ok};
            rem_ff <= sub_ok ? rem_sub[XLEN-1:0] : rem_shift[XLEN-1:0];  // Restore on borrow
        end
    end

    assign done_o = done_ff;
    assign quo_o  = quo_ff;
    assign rem_o  = rem_ff;
    assign busy_o = busy_ff;

    // The divide unit must wait for the running division
    assert property (@(posedge clk) disable iff (!rst_n) start_i |-> !busy_o)
        else $error("divider started while an iteration is running");

endmodule

/* divide.sv */
// Divide unit of the M-extension
// Operand capture with sign stripping, hold on stall, clear on flush
// Divider start, result sign fix, registered acknowledge and result
module divide #(
    parameter int unsigned XLEN = 32
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [m_ext_pkg::ALU_D_OPS_W-1:0] alu_d_ops_i,
    input  logic [XLEN-1:0]                   alu_operand_1_i,
    input  logic [XLEN-1:0]                   alu_operand_2_i,
    input  logic                              stall_i,
    input  logic                              flush_i,
    output logic                              div_req_o,
    output logic                              div_ack_o,
    output logic [XLEN-1:0]                   alu_d_result_o
);

    m_ext_pkg::alu_d_ops_e alu_d_ops;
    m_ext_pkg::alu_d_ops_e alu_d_ops_ff;

    logic            signed_op;
    logic [XLEN-1:0] opr1_abs;
    logic [XLEN-1:0] opr2_abs;
    logic [XLEN-1:0] opr1_ff;
    logic [XLEN-1:0] opr2_ff;
    logic            opr1_sign_ff;
    logic            opr2_sign_ff;

    logic            div_start;
    logic            div_done;
    logic            div_busy;
    logic [XLEN-1:0] quo_u;
    logic [XLEN-1:0] rem_u;

    logic            ack_next;
    logic            ack_ff;
    logic [XLEN-1:0] result_next;
    logic [XLEN-1:0] result_ff;

    assign alu_d_ops = m_ext_pkg::alu_d_ops_e'(alu_d_ops_i);
    assign signed_op = (alu_d_ops == m_ext_pkg::ALU_D_OPS_DIV) ||
                       (alu_d_ops == m_ext_pkg::ALU_D_OPS_REM);

    // Magnitudes for the signed ops
    assign opr1_abs = (signed_op && alu_operand_1_i[XLEN-1]) ?
                      (~alu_operand_1_i + 1'b1) : alu_operand_1_i;
    assign opr2_abs = (signed_op && alu_operand_2_i[XLEN-1]) ?
                      (~alu_operand_2_i + 1'b1) : alu_operand_2_i;

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            alu_d_ops_ff <= m_ext_pkg::ALU_D_OPS_NONE;
        end else if (!stall_i) begin
            // Execute still shows the finished op in the ack cycle
            alu_d_ops_ff <= ack_ff ? m_ext_pkg::ALU_D_OPS_NONE : alu_d_ops;
        end
    end

    always_ff @(posedge clk) begin
        if (flush_i) begin
            opr1_ff      <= '0;
            opr2_ff      <= '0;
            opr1_sign_ff <= 1'b0;
            opr2_sign_ff <= 1'b0;
        end else if (!stall_i) begin
            opr1_ff      <= opr1_abs;
            opr2_ff      <= opr2_abs;
            opr1_sign_ff <= alu_operand_1_i[XLEN-1];
            opr2_sign_ff <= alu_operand_2_i[XLEN-1];
        end
    end

    // One start per request, never while a result is pending
    assign div_start = alu_d_ops_ff[2] & ~(ack_next | ack_ff) & ~div_busy;
    assign ack_next  = div_done & alu_d_ops_ff[2];

    always_comb begin
        result_next = '0;
        case (alu_d_ops_ff)
            m_ext_pkg::ALU_D_OPS_DIV: begin
                // Top bit set covers overflow and division by zero
                result_next = ((opr1_sign_ff ^ opr2_sign_ff) && !quo_u[XLEN-1]) ?
                              (~quo_u + 1'b1) : quo_u;
            end
            m_ext_pkg::ALU_D_OPS_DIVU: result_next = quo_u;
            m_ext_pkg::ALU_D_OPS_REM: begin
                result_next = opr1_sign_ff ? (~rem_u + 1'b1) : rem_u;  // Follows the dividend
            end
            m_ext_pkg::ALU_D_OPS_REMU: result_next = rem_u;
            default: result_next = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            ack_ff <= 1'b0;
        end else begin
            ack_ff <= ack_next;
        end
    end

    always_ff @(posedge clk) begin
        if (ack_next) begin
            result_ff <= result_next;
        end
    end

    divider #(
        .XLEN (XLEN)
    ) u_divider (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (div_start),
        .abort_i (flush_i),
        .opr1_i  (opr1_ff),
        .opr2_i  (opr2_ff),
        .done_o  (div_done),
        .quo_o   (quo_u),
        .rem_o   (rem_u),
        .busy_o  (div_busy)
    );

    assign div_req_o      = alu_d_ops_ff[2];
    assign div_ack_o      = ack_ff;
    assign alu_d_result_o = result_ff;

    assert property (@(posedge clk) disable iff (!rst_n) div_ack_o |=> !div_ack_o)
        else $error("acknowledge held for more than one cycle");

    // Divider sees a single start pulse per request
    assert property (@(posedge clk) disable iff (!rst_n) div_start |=> !div_start)
        else $error("divider start held for more than one cycle");

endmodule

/* div_fwd_stall.sv */
// Forward-stall control for the divide unit
// Outstanding division flag, pipeline stall and flush forwarding
module div_fwd_stall (
    input  logic clk,
    input  logic rst_n,
    input  logic div_req_i,
    input  logic div_ack_i,
    input  logic flush_i,
    output logic stall_o,
    output logic flush_o
);

    logic outstanding_ff;

    // Set by a request, dropped on acknowledge or flush
    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            outstanding_ff <= 1'b0;
        end else if (div_ack_i) begin
            outstanding_ff <= 1'b0;
        end else if (div_req_i) begin
            outstanding_ff <= 1'b1;
        end
    end

    // Released in the acknowledge cycle so execute advances at that edge
    assign stall_o = (div_req_i | outstanding_ff) & ~div_ack_i;
    assign flush_o = flush_i;     // Divide unit cancels on the same edge

    // Pipeline held right up to the result
    assert property (@(posedge clk) disable iff (!rst_n) div_ack_i |-> $past(stall_o))
        else $error("acknowledge arrived without a stalled request before it");

endmodule

/* m_ext_div_top.sv */
// Top level of the M-extension divide path
// Divide unit and its forward-stall control
module m_ext_div_top #(
    parameter int unsigned XLEN = m_ext_pkg::XLEN
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  m_ext_pkg::alu_d_ops_e alu_d_ops_i,
    input  logic [XLEN-1:0]       operand_1_i,
    input  logic [XLEN-1:0]       operand_2_i,
    input  logic                  flush_i,
    output logic                  stall_o,
    output logic [XLEN-1:0]       result_o,
    output logic                  result_valid_o
);

    logic div_req;
    logic div_flush;

    divide #(
        .XLEN (XLEN)
    ) u_divide (
        .clk             (clk),
        .rst_n           (rst_n),
        .alu_d_ops_i     (alu_d_ops_i),
        .alu_operand_1_i (operand_1_i),
        .alu_operand_2_i (operand_2_i),
        .stall_i         (stall_o),          // Own stall holds the captured op
        .flush_i         (div_flush),
        .div_req_o       (div_req),
        .div_ack_o       (result_valid_o),
        .alu_d_result_o  (result_o)
    );

    div_fwd_stall u_div_fwd_stall (
        .clk       (clk),
        .rst_n     (rst_n),
        .div_req_i (div_req),
        .div_ack_i (result_valid_o),
        .flush_i   (flush_i),
        .stall_o   (stall_o),
        .flush_o   (div_flush)
    );

endmodule

/* tb_m_ext_div.sv */
// Testbench for the M-extension divide path
// Golden vectors from div_golden.txt plus LCG driven DIVU and REMU cases
// Checks results, stall handshake, zero divisor latency, flush and reset state
module tb_m_ext_div;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned XLEN = m_ext_pkg::XLEN;
    localparam int N_RAND      = 8;
    localparam int FLUSH_CASES = 2;   // Cancelled division and the one after it

    logic                  clk;
    logic                  rst_n;
    m_ext_pkg::alu_d_ops_e alu_d_ops;
    logic [XLEN-1:0]       operand_1;
    logic [XLEN-1:0]       operand_2;
    logic                  flush_i;
    logic                  stall_o;
    logic [XLEN-1:0]       result_o;
    logic                  result_valid_o;

    m_ext_pkg::alu_d_ops_e vec_op[$];
    logic [XLEN-1:0]       vec_a[$];
    logic [XLEN-1:0]       vec_b[$];
    logic [XLEN-1:0]       vec_exp[$];

    int          err_count   = 0;
    int          pass_count  = 0;
    int          fail_count  = 0;
    int          cycle_count = 0;
    int          limit_cycles = 0;   // Zero until the vector count is known
    logic [31:0] lcg_state   = 32'd32;

    m_ext_div_top #(
        .XLEN (XLEN)
    ) u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .alu_d_ops_i    (alu_d_ops),
        .operand_1_i    (operand_1),
        .operand_2_i    (operand_2),
        .flush_i        (flush_i),
        .stall_o        (stall_o),
        .result_o       (result_o),
        .result_valid_o (result_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Run limit from the number of cases
    initial begin
        while (limit_cycles == 0 || cycle_count < limit_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout, the divide tests did not finish within %0d clock cycles",
                 limit_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    function automatic logic [XLEN-1:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string what, input logic [XLEN-1:0] actual,
                               input logic [XLEN-1:0] expected);
        if (actual !== expected) begin
            err_count++;
            $display("Error at time %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic finish_test(input string tag, input int errs_before);
        if (err_count == errs_before) begin
            pass_count++;
            $display("ok      %s", tag);
        end else begin
            fail_count++;
            $display("FAILED  %s", tag);
        end
    endtask

    // Inputs change 5 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic load_vectors(output bit ok);
        int              fd;
        int              rc;
        string           line;
        logic [XLEN-1:0] w_op;
        logic [XLEN-1:0] w_a;
        logic [XLEN-1:0] w_b;
        logic [XLEN-1:0] w_exp;
        ok = 1'b0;
        fd = $fopen("div_golden.txt", "r");
        if (fd == 0) begin
            $display("The golden file div_golden.txt could not be opened");
        end else begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                // Comment lines do not scan as four hex fields
                if (rc > 0 && $sscanf(line, "%h %h %h %h", w_op, w_a, w_b, w_exp) == 4) begin
                    vec_op.push_back(m_ext_pkg::alu_d_ops_e'(w_op[2:0]));
                    vec_a.push_back(w_a);
                    vec_b.push_back(w_b);
                    vec_exp.push_back(w_exp);
                end
            end
            $fclose(fd);
            ok = (vec_op.size() > 0);
            if (!ok) begin
                $display("The golden file div_golden.txt holds no vectors");
            end
        end
    endtask

    task automatic reset_test();
        int errs_before;
        errs_before = err_count;
        repeat (10) @(posedge clk);
        #5;
        rst_n = 1'b1;
        check_value("stall_o after reset", XLEN'(stall_o), XLEN'(0));
        check_value("result_valid_o after reset", XLEN'(result_valid_o), XLEN'(0));
        finish_test("reset state", errs_before);
    endtask

    // One request from presentation to the cycle after the acknowledge
    task automatic run_case(input m_ext_pkg::alu_d_ops_e op, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b, input logic [XLEN-1:0] exp);
        int    errs_before;
        int    n;
        string tag;
        errs_before = err_count;
        tag = $sformatf("%s %h %h -> %h", op.name(), a, b, exp);
        alu_d_ops = op;
        operand_1 = a;
        operand_2 = b;
        next_cycle();                 // Capture edge passed
        n = 1;
        while (!result_valid_o) begin
            check_value("stall_o while dividing", XLEN'(stall_o), XLEN'(1));
            next_cycle();
            n++;
        end
        check_value("result_o", result_o, exp);
        check_value("stall_o in acknowledge cycle", XLEN'(stall_o), XLEN'(0));
        if (b == '0) begin
            check_value("cycles to result for zero divisor", XLEN'(n), XLEN'(3));
        end
        next_cycle();
        check_value("result_valid_o after one cycle", XLEN'(result_valid_o), XLEN'(0));
        alu_d_ops = m_ext_pkg::ALU_D_OPS_NONE;   // Execute drops the finished op
        finish_test($sformatf("%s in %0d cycles", tag, n), errs_before);
    endtask

    task automatic flush_test();
        int errs_before;
        int k;
        int acks;
        errs_before = err_count;
        acks = 0;
        alu_d_ops = m_ext_pkg::ALU_D_OPS_DIVU;
        operand_1 = 32'hffff_ffff;
        operand_2 = 32'h0000_0003;
        repeat (10) next_cycle();     // Well inside the iterations
        check_value("stall_o during long division", XLEN'(stall_o), XLEN'(1));
        flush_i   = 1'b1;
        alu_d_ops = m_ext_pkg::ALU_D_OPS_NONE;
        next_cycle();
        check_value("stall_o after flush", XLEN'(stall_o), XLEN'(0));
        flush_i = 1'b0;
        for (k = 0; k < XLEN + 4; k++) begin
            acks += int'(result_valid_o);
            next_cycle();
        end
        check_value("acknowledges after flush", XLEN'(acks), XLEN'(0));
        finish_test("flush cancels a long DIVU", errs_before);
        // -20 / 3 truncates toward zero
        run_case(m_ext_pkg::ALU_D_OPS_DIV, 32'hffff_ffec, 32'h0000_0003, 32'hffff_fffa);
    endtask

    initial begin
        bit                    loaded;
        int                    i;
        m_ext_pkg::alu_d_ops_e op;
        logic [XLEN-1:0]       a;
        logic [XLEN-1:0]       b;
        logic [XLEN-1:0]       exp;
        rst_n     = 1'b0;
        alu_d_ops = m_ext_pkg::ALU_D_OPS_NONE;
        operand_1 = '0;
        operand_2 = '0;
        flush_i   = 1'b0;
        load_vectors(loaded);
        limit_cycles = (vec_op.size() + N_RAND + FLUSH_CASES) * (XLEN + 6) + 50;
        reset_test();
        if (loaded) begin
            for (i = 0; i < vec_op.size(); i++) begin
                run_case(vec_op[i], vec_a[i], vec_b[i], vec_exp[i]);
            end
            flush_test();
            for (i = 0; i < N_RAND; i++) begin
                op = (i % 2 == 0) ? m_ext_pkg::ALU_D_OPS_DIVU : m_ext_pkg::ALU_D_OPS_REMU;
                a  = lcg_next();
                b  = lcg_next() >> (i * 3);   // Smaller divisors, longer quotients
                if (b == '0) begin
                    b = XLEN'(1);
                end
                exp = (op == m_ext_pkg::ALU_D_OPS_DIVU) ? a / b : a % b;
                run_case(op, a, b, exp);
            end
        end else begin
            fail_count++;
        end
        $display("Tests: %0d passed, %0d failed, %0d check errors",
                 pass_count, fail_count, err_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* div_golden.txt */
// op operand_1 operand_2 expected, all hex
// op codes 4 DIV, 5 DIVU, 6 REM, 7 REMU
4 00000014 00000003 00000006
4 ffffffec 00000003 fffffffa
4 00000014 fffffffd fffffffa
4 ffffffec fffffffd 00000006
4 80000000 ffffffff 80000000
4 00000007 00000000 ffffffff
4 fffffff9 00000000 ffffffff
4 80000000 00000002 c0000000
4 7fffffff 00000010 07ffffff
5 00000014 00000003 00000006
5 ffffffec 00000003 5555554e
5 00000014 fffffffd 00000000
5 80000000 ffffffff 00000000
5 12345678 00000000 ffffffff
5 ffffffff 00000001 ffffffff
6 00000014 00000003 00000002
6 ffffffec 00000003 fffffffe
6 00000014 fffffffd 00000002
6 ffffffec fffffffd fffffffe
6 80000000 ffffffff 00000000
6 fffffff9 00000000 fffffff9
6 00000007 00000000 00000007
7 00000014 00000003 00000002
7 ffffffec 00000003 00000002
7 00000014 fffffffd 00000014
7 80000000 ffffffff 80000000
7 12345678 00000000 12345678
7 ffffffff 00010000 0000ffff

/* flist.f */
m_ext_pkg.sv
divider.sv
divide.sv
div_fwd_stall.sv
m_ext_div_top.sv
tb_m_ext_div.sv

/* Makefile */
# Verilator build and run of the M-extension divide testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_m_ext_div
FLIST     := flist.f

MDIR   := obj_dir
BIN    := $(MDIR)/V$(TOP)
LOG    := sim.log
SRCS   := $(shell cat $(FLIST))
GOLDEN := div_golden.txt

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FLIST)

run: $(BIN) $(GOLDEN)
	./$(BIN) | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(MDIR) $(LOG)
